// File: Bender.yml
package:
  name: cpu16

export_include_dirs:
  - design

sources:
  - design/cpu_pkg.sv
  - design/alu.sv
  - design/register_file.sv
  - design/execute_unit.sv
  - design/instr_queue.sv
  - design/fetch_unit.sv
  - design/mem_arbiter.sv
  - design/cpu_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/cpu_tb.sv

// File: bench/cpu_tb_model.svh
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// ********************
// Random numbers
// ********************

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Upper bits only, the low ones repeat quickly
function automatic int rand_below(input int limit);
  return int'((lcg_next() >> 16) % limit);
endfunction

// ********************
// Instruction encoding
// ********************

function automatic word_t enc_rrr(input opcode_e op, input int rd, input int rs, input int rt);
  return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
endfunction

function automatic word_t enc_imm(input opcode_e op, input int rd, input int rs, input int imm);
  return {op, 3'(rd), 3'(rs), 6'(imm)};
endfunction

function automatic word_t enc_movi(input int rd, input int imm);
  return {OP_MOVI, 3'(rd), 9'(imm)};
endfunction

function automatic void emit(input word_t instr);
  prog_q.push_back(instr);
endfunction

// r7 = 2048, the base of the data region
function automatic void emit_base();
  emit(enc_movi(7, 256));
  for (int i = 0; i < 3; i++) begin
    emit(enc_rrr(OP_ADD, 7, 7, 7));
  end
endfunction

// ********************
// Directed programs
// ********************

function automatic void build_alu_program();
  prog_q.delete();
  emit_base();
  emit(enc_movi(1, 9'h1a5));
  emit(enc_movi(2, 9'h0f3));
  emit(enc_imm(OP_ADDI, 3, 1, 45));
  emit(enc_rrr(OP_ADD, 4, 1, 2));
  emit(enc_rrr(OP_SUB, 5, 2, 1));
  emit(enc_rrr(OP_AND, 6, 1, 2));
  for (int i = 1; i < 7; i++) begin
    emit(enc_imm(OP_STR, i, 7, i - 1));
  end
  emit(enc_rrr(OP_ORR, 1, 1, 2));
  emit(enc_rrr(OP_EOR, 2, 4, 5));
  emit(enc_imm(OP_ADDI, 6, 5, 63));
  emit(enc_imm(OP_STR, 1, 7, 6));
  emit(enc_imm(OP_STR, 2, 7, 7));
  emit(enc_imm(OP_STR, 6, 7, 8));
  emit(enc_rrr(OP_HALT, 0, 0, 0));
endfunction

function automatic void build_carry_program();
  prog_q.delete();
  emit_base();
  emit(enc_movi(1, 0));
  emit(enc_movi(2, 1));
  // 0 - 1 borrows, so C clears
  emit(enc_rrr(OP_SUB, 1, 1, 2));
  emit(enc_rrr(OP_ADC, 3, 2, 2));
  emit(enc_imm(OP_STR, 3, 7, 0));
  // Wraps to zero with carry
  emit(enc_rrr(OP_ADD, 4, 1, 2));
  emit(enc_rrr(OP_ADC, 3, 2, 2));
  emit(enc_imm(OP_STR, 3, 7, 1));
  // Logic ops leave C alone
  emit(enc_rrr(OP_AND, 5, 1, 2));
  emit(enc_rrr(OP_EOR, 5, 5, 1));
  emit(enc_rrr(OP_ADC, 3, 1, 5));
  emit(enc_imm(OP_STR, 3, 7, 2));
  emit(enc_rrr(OP_SUB, 6, 2, 1));
  emit(enc_rrr(OP_ORR, 5, 6, 2));
  emit(enc_rrr(OP_ADC, 3, 6, 2));
  emit(enc_imm(OP_STR, 3, 7, 3));
  emit(enc_imm(OP_ADDI, 4, 1, 1));
  emit(enc_rrr(OP_ADC, 3, 4, 4));
  emit(enc_imm(OP_STR, 3, 7, 4));
  // Equal operands, no borrow
  emit(enc_rrr(OP_SUB, 5, 2, 2));
  emit(enc_rrr(OP_ADC, 3, 2, 2));
  emit(enc_imm(OP_STR, 3, 7, 5));
  emit(enc_imm(OP_STR, 5, 7, 6));
  emit(enc_rrr(OP_HALT, 0, 0, 0));
endfunction

function automatic void build_load_store_program();
  prog_q.delete();
  emit_base();
  emit(enc_movi(1, 9'h123));
  emit(enc_movi(2, 9'h0ab));
  emit(enc_imm(OP_STR, 1, 7, 10));
  emit(enc_imm(OP_STR, 2, 7, 11));
  emit(enc_imm(OP_LDR, 3, 7, 10));
  emit(enc_imm(OP_LDR, 4, 7, 11));
  emit(enc_imm(OP_LDR, 5, 7, 20));
  emit(enc_imm(OP_STR, 3, 7, 30));
  emit(enc_imm(OP_STR, 4, 7, 31));
  emit(enc_imm(OP_STR, 5, 7, 32));
  // Codes 11 to 14 and NOP, r2 must survive them
  emit(16'hb5c3);
  emit(16'hc000);
  emit(16'hdfff);
  emit(16'he248);
  emit(enc_rrr(OP_NOP, 2, 3, 4));
  emit(enc_rrr(OP_ADD, 6, 3, 4));
  emit(enc_imm(OP_STR, 6, 7, 33));
  emit(enc_imm(OP_LDR, 1, 7, 33));
  emit(enc_imm(OP_STR, 1, 7, 63));
  // Second base further up the region
  emit(enc_movi(0, 9'h1f0));
  emit(enc_rrr(OP_ADD, 0, 0, 7));
  emit(enc_imm(OP_STR, 2, 0, 5));
  emit(enc_imm(OP_LDR, 6, 0, 5));
  emit(enc_imm(OP_STR, 6, 7, 34));
  emit(enc_rrr(OP_HALT, 0, 0, 0));
endfunction

// Random ops never write r7, so every access stays in the data region
function automatic void build_random_program(input int length);
  opcode_e rrr_ops [6] = '{OP_ADD, OP_SUB, OP_ADC, OP_AND, OP_ORR, OP_EOR};
  int      kind;
  int      rd;
  int      rs;
  int      rt;
  int      imm;

  prog_q.delete();
  emit_base();
  for (int i = 0; i < length; i++) begin
    kind = rand_below(11);
    rd   = rand_below(7);
    rs   = rand_below(8);
    rt   = rand_below(8);
    imm  = rand_below(512);
    case (kind)
      0:       emit(enc_movi(rd, imm));
      1:       emit(enc_imm(OP_ADDI, rd, rs, imm % 64));
      8:       emit(enc_imm(OP_LDR, rd, 7, imm % 64));
      9:       emit(enc_imm(OP_STR, rs, 7, imm % 64));
      10:      emit(enc_rrr(OP_NOP, rd, rs, rt));
      default: emit(enc_rrr(rrr_ops[kind - 2], rd, rs, rt));
    endcase
  end
  emit(enc_rrr(OP_HALT, 0, 0, 0));
endfunction

// ********************
// Reference model
// ********************

// Runs model_mem to HALT and records every store in order
function automatic void run_model();
  word_t       regs [8];
  word_t       ins;
  word_t       a;
  word_t       b;
  word_t       res;
  logic [16:0] wide;
  logic [3:0]  opc;
  logic [2:0]  rd;
  logic        n_f;
  logic        z_f;
  logic        c_f;
  logic        v_f;
  logic        cin;
  logic        arith;
  int          sres;
  int          pc;
  int          steps;
  int          ea;
  bit          done;

  foreach (regs[i]) begin
    regs[i] = '0;
  end
  {n_f, z_f, c_f, v_f} = 4'b0000;
  exp_addr_q.delete();
  exp_data_q.delete();
  pc    = 0;
  steps = 0;
  done  = 1'b0;
  while (!done && steps < MEM_WORDS) begin
    ins   = model_mem[pc];
    pc    = (pc + 1) % MEM_WORDS;
    steps = steps + 1;
    opc   = ins[15:12];
    rd    = ins[11:9];
    a     = regs[ins[8:6]];
    b     = regs[ins[5:3]];
    ea    = (int'(a[11:0]) + int'(ins[5:0])) % MEM_WORDS;
    arith = 1'b0;
    case (opc)
      OP_MOVI: regs[rd] = word_t'(ins[8:0]);
      OP_ADDI, OP_ADD, OP_ADC: begin
        if (opc == OP_ADDI) begin
          b = word_t'(ins[5:0]);
        end
        cin   = (opc == OP_ADC) ? c_f : 1'b0;
        wide  = {1'b0, a} + {1'b0, b} + 17'(cin);
        sres  = int'($signed(a)) + int'($signed(b)) + int'(cin);
        arith = 1'b1;
      end
      OP_SUB: begin
        wide  = {1'b0, a} + {1'b0, ~b} + 17'd1;
        sres  = int'($signed(a)) - int'($signed(b));
        arith = 1'b1;
      end
      OP_AND, OP_ORR, OP_EOR: begin
        res      = (opc == OP_AND) ? (a & b) : (opc == OP_ORR) ? (a | b) : (a ^ b);
        regs[rd] = res;
        n_f      = res[15];
        z_f      = (res == '0);
      end
      OP_LDR:  regs[rd] = model_mem[ea];
      OP_STR: begin
        model_mem[ea] = regs[rd];
        exp_addr_q.push_back(addr_t'(ea));
        exp_data_q.push_back(regs[rd]);
      end
      OP_HALT: done = 1'b1;
      default: ;
    endcase
    if (arith) begin
      res      = wide[15:0];
      regs[rd] = res;
      n_f      = res[15];
      z_f      = (res == '0);
      c_f      = wide[16];
      v_f      = (sres > 32767) || (sres < -32768);
    end
  end
endfunction

`endif

// File: bench/cpu_tb.sv
`default_nettype none

`include "cpu_defines.svh"

module cpu_tb;

  import cpu_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int MEM_WORDS  = 4096;
  localparam int DATA_BASE  = 2048;
  localparam int RUN_LIMIT  = 20000;

  logic  clock;
  logic  arst_n;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  word_t pwdata;
  word_t prdata;
  logic  pready;
  logic  halted;

  word_t       mem [MEM_WORDS];
  word_t       model_mem [MEM_WORDS];
  word_t       prog_q [$];
  addr_t       exp_addr_q [$];
  word_t       exp_data_q [$];
  logic [31:0] lcg_state;
  logic        use_waits;
  int          wait_left;
  int          store_idx;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  string       test_name;

  `include "cpu_tb_model.svh"

  cpu_top dut (
    .clock   (clock),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .halted  (halted)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // ********************
  // APB memory
  // ********************

  // Outputs seen here are registered, so they are settled by now
  initial begin
    pready    = 1'b0;
    prdata    = '0;
    wait_left = 0;
    forever begin
      @(posedge clock);
      #DRIVE_DLY;
      pready = 1'b0;
      if (psel && !penable) begin
        wait_left = use_waits ? rand_below(4) : 0;
      end else if (psel && penable) begin
        if (wait_left == 0) begin
          pready = 1'b1;
          prdata = mem[paddr];
          if (pwrite) begin
            mem[paddr] = pwdata;
          end
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  // ********************
  // Store comparison
  // ********************

  initial begin
    forever begin
      @(negedge clock);
      if (psel && penable && pready && pwrite) begin
        if (store_idx >= exp_addr_q.size()) begin
          $display("%s: store of %h to address %0d was not expected by the model",
                   test_name, pwdata, paddr);
          test_errors = test_errors + 1;
        end else begin
          if (paddr !== exp_addr_q[store_idx]) begin
            report_mismatch($sformatf("store %0d address", store_idx),
                            exp_addr_q[store_idx], paddr);
          end
          if (pwdata !== exp_data_q[store_idx]) begin
            report_mismatch($sformatf("store %0d data", store_idx),
                            exp_data_q[store_idx], pwdata);
          end
        end
        store_idx = store_idx + 1;
      end
    end
  end

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
    test_errors = test_errors + 1;
  endtask

  // Data pattern mixes every address bit
  function automatic word_t fill_word(input int addr);
    return word_t'(addr * 32'h9e37) ^ word_t'(addr);
  endfunction

  function automatic void load_memory();
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = (a < DATA_BASE) ? word_t'(0) : fill_word(a);
    end
    foreach (prog_q[i]) begin
      mem[i] = prog_q[i];
    end
    model_mem = mem;
  endfunction

  // ********************
  // Test sequencing
  // ********************

  // Reset goes in away from the memory model's drive point
  task automatic start_test(input string name);
    @(negedge clock);
    arst_n = 1'b0;
    @(negedge clock);
    test_name   = name;
    test_errors = 0;
    store_idx   = 0;
    load_memory();
    run_model();
    if ({psel, penable, pwrite, halted} !== 4'b0000) begin
      report_mismatch("outputs in reset", 4'b0000, {psel, penable, pwrite, halted});
    end
    repeat (3) @(posedge clock);
    #DRIVE_DLY;
    arst_n = 1'b1;
  endtask

  task automatic check_first_fetch();
    int cycles;

    cycles = 0;
    while (!psel && cycles < 4) begin
      @(negedge clock);
      cycles = cycles + 1;
    end
    if (!psel) begin
      $display("%s: no transfer started after reset", test_name);
      test_errors = test_errors + 1;
    end else begin
      if (paddr !== addr_t'(`CPU_RESET_PC)) begin
        report_mismatch("first fetch address", `CPU_RESET_PC, paddr);
      end
      if ({penable, pwrite} !== 2'b00) begin
        report_mismatch("first setup penable and pwrite", 2'b00, {penable, pwrite});
      end
    end
  endtask

  task automatic finish_test();
    int cycles;

    cycles = 0;
    while (!halted && cycles < RUN_LIMIT) begin
      @(negedge clock);
      cycles = cycles + 1;
    end
    if (!halted) begin
      $display("%s: timed out, halted did not rise within %0d cycles", test_name, RUN_LIMIT);
      test_errors = test_errors + 1;
    end else begin
      @(negedge clock);
      if (halted !== 1'b1) begin
        report_mismatch("halted held", 1, halted);
      end
      if (store_idx != exp_addr_q.size()) begin
        report_mismatch("store count", exp_addr_q.size(), store_idx);
      end
      for (int a = DATA_BASE; a < MEM_WORDS; a++) begin
        if (mem[a] !== model_mem[a]) begin
          report_mismatch($sformatf("mem[%0d]", a), model_mem[a], mem[a]);
        end
      end
    end
    if (test_errors == 0) begin
      tests_passed = tests_passed + 1;
      $display("%-12s ok, %0d stores checked", test_name, store_idx);
    end else begin
      tests_failed = tests_failed + 1;
      $display("%-12s failed with %0d errors", test_name, test_errors);
    end
  endtask

  initial begin
    arst_n       = 1'b0;
    lcg_state    = 32'he03a;
    use_waits    = 1'b0;
    store_idx    = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_name    = "none";

    prog_q.delete();
    emit(enc_rrr(OP_HALT, 0, 0, 0));
    start_test("reset_state");
    check_first_fetch();
    finish_test();

    build_alu_program();
    start_test("alu_ops");
    finish_test();

    build_carry_program();
    start_test("carry_chain");
    finish_test();

    build_load_store_program();
    start_test("load_store");
    finish_test();

    // Random wait states from here on
    use_waits = 1'b1;
    for (int i = 0; i < 4; i++) begin
      build_random_program(48);
      start_test($sformatf("random_%0d", i));
      finish_test();
    end

    $display("%0d tests, %0d passed, %0d failed",
             tests_passed + tests_failed, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu (
  input  wire cpu_pkg::alu_op_e op,
  input  wire cpu_pkg::word_t   a,
  input  wire cpu_pkg::word_t   b,
  input  wire                   carry_in,
  output cpu_pkg::word_t        result,
  output logic                  n,
  output logic                  z,
  output logic                  c,
  output logic                  v
);

  import cpu_pkg::*;

  localparam int MSB = $bits(word_t) - 1;

  word_t b_eff;
  word_t sum;
  logic  cin_eff;
  logic  carry_out;
  logic  overflow;

  // Subtract as a plus inverted b plus one
  assign b_eff = (op == ALU_SUB) ? ~b : b;

  always_comb begin
    case (op)
      ALU_SUB: cin_eff = 1'b1;
      ALU_ADC: cin_eff = carry_in;
      default: cin_eff = 1'b0;
    endcase
  end

  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_eff} + cin_eff;

  // Same input signs, different result sign
  assign overflow = (a[MSB] == b_eff[MSB]) && (sum[MSB] != a[MSB]);

  always_comb begin
    c = carry_in;
    v = 1'b0;
    case (op)
      ALU_ADD, ALU_ADC, ALU_SUB: begin
        result = sum;
        c      = carry_out;
        v      = overflow;
      end
      ALU_AND: result = a & b;
      ALU_ORR: result = a | b;
      ALU_EOR: result = a ^ b;
      default: result = b;
    endcase
  end

  assign n = result[MSB];
  assign z = (result == '0);

endmodule

`default_nettype wire

// File: design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ********************
// Datapath sizes
// ********************

// Register and memory word width
`define CPU_DATA_W 16

// Halfword address into the shared memory
`define CPU_ADDR_W 12

// General purpose registers
`define CPU_REG_COUNT 8

// ********************
// Fetch side
// ********************

// Instruction queue entries, a power of two
`define CPU_QUEUE_DEPTH 4

// First fetch address
`define CPU_RESET_PC 0

`endif

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

  // One data or instruction halfword
  typedef logic [`CPU_DATA_W-1:0] word_t;

  // Halfword address
  typedef logic [`CPU_ADDR_W-1:0] addr_t;

  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

  // Instruction bits 15 to 12, codes not listed run as NOP
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_MOVI = 4'd1,
    OP_ADDI = 4'd2,
    OP_ADD  = 4'd3,
    OP_SUB  = 4'd4,
    OP_ADC  = 4'd5,
    OP_AND  = 4'd6,
    OP_ORR  = 4'd7,
    OP_EOR  = 4'd8,
    OP_LDR  = 4'd9,
    OP_STR  = 4'd10,
    OP_HALT = 4'd15
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_SUB,
    ALU_AND,
    ALU_ORR,
    ALU_EOR,
    ALU_PASS_B
  } alu_op_e;

endpackage

`default_nettype wire

// File: design/cpu_top.sv
`default_nettype none

module cpu_top (
  input  wire                 clock,
  input  wire                 arst_n,
  output logic                psel,
  output logic                penable,
  output logic                pwrite,
  output cpu_pkg::addr_t      paddr,
  output cpu_pkg::word_t      pwdata,
  input  wire cpu_pkg::word_t prdata,
  input  wire                 pready,
  output logic                halted
);

  import cpu_pkg::*;

  // Fetch and queue
  logic  fetch_req;
  addr_t fetch_addr;
  logic  fetch_done;
  logic  push;
  word_t push_data;
  logic  full;

  // Queue to execute
  word_t head;
  logic  empty;
  logic  pop;

  // Data channel
  logic  data_req;
  logic  data_write;
  addr_t data_addr;
  word_t data_wdata;
  logic  data_done;
  word_t rdata;

  fetch_unit u_fetch (
    .clock      (clock),
    .arst_n     (arst_n),
    .full       (full),
    .fetch_done (fetch_done),
    .rdata      (rdata),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .push       (push),
    .push_data  (push_data)
  );

  instr_queue u_queue (
    .clock     (clock),
    .arst_n    (arst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .full      (full)
  );

  execute_unit u_execute (
    .clock      (clock),
    .arst_n     (arst_n),
    .head       (head),
    .empty      (empty),
    .pop        (pop),
    .data_done  (data_done),
    .rdata      (rdata),
    .data_req   (data_req),
    .data_write (data_write),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .halted     (halted)
  );

  mem_arbiter u_arbiter (
    .clock      (clock),
    .arst_n     (arst_n),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .data_req   (data_req),
    .data_write (data_write),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .fetch_done (fetch_done),
    .data_done  (data_done),
    .rdata      (rdata),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready)
  );

endmodule

`default_nettype wire

// File: design/execute_unit.sv
`default_nettype none

module execute_unit (
  input  wire                 clock,
  input  wire                 arst_n,
  input  wire cpu_pkg::word_t head,
  input  wire                 empty,
  output logic                pop,
  input  wire                 data_done,
  input  wire cpu_pkg::word_t rdata,
  output logic                data_req,
  output logic                data_write,
  output cpu_pkg::addr_t      data_addr,
  output cpu_pkg::word_t      data_wdata,
  output logic                halted
);

  import cpu_pkg::*;

  opcode_e    op;
  reg_idx_t   rd_idx;
  reg_idx_t   rs_idx;
  reg_idx_t   rt_idx;
  word_t      imm;
  word_t      rs_data;
  word_t      rt_data;
  word_t      rd_data;
  word_t      alu_b;
  word_t      alu_result;
  word_t      wr_data;
  alu_op_e    alu_op;
  logic       alu_n;
  logic       alu_z;
  logic       alu_c;
  logic       alu_v;
  logic       valid;
  logic       is_mem;
  logic       writes_reg;
  logic       sets_nz;
  logic       sets_cv;
  logic       wr_en;
  logic [3:0] flags_q;
  logic       halted_q;

  // ********************
  // Decode
  // ********************

  assign op     = opcode_e'(head[15:12]);
  assign rd_idx = head[11:9];
  assign rs_idx = head[8:6];
  assign rt_idx = head[5:3];

  // MOVI takes nine immediate bits, ADDI six
  assign imm   = (op == OP_MOVI) ? word_t'(head[8:0]) : word_t'(head[5:0]);
  assign alu_b = (op == OP_MOVI || op == OP_ADDI) ? imm : rt_data;

  always_comb begin
    alu_op     = ALU_PASS_B;
    writes_reg = 1'b0;
    sets_nz    = 1'b0;
    sets_cv    = 1'b0;
    is_mem     = 1'b0;
    case (op)
      OP_MOVI: writes_reg = 1'b1;
      OP_ADDI, OP_ADD, OP_SUB, OP_ADC: begin
        alu_op     = (op == OP_SUB) ? ALU_SUB : (op == OP_ADC) ? ALU_ADC : ALU_ADD;
        writes_reg = 1'b1;
        sets_nz    = 1'b1;
        sets_cv    = 1'b1;
      end
      OP_AND, OP_ORR, OP_EOR: begin
        alu_op     = (op == OP_AND) ? ALU_AND : (op == OP_ORR) ? ALU_ORR : ALU_EOR;
        writes_reg = 1'b1;
        sets_nz    = 1'b1;
      end
      OP_LDR: begin
        is_mem     = 1'b1;
        writes_reg = 1'b1;
      end
      OP_STR:  is_mem = 1'b1;
      default: alu_op = ALU_PASS_B;
    endcase
  end

  // ********************
  // Issue and retire
  // ********************

  assign valid = !empty && !halted_q;

  // Loads and stores wait for their transfer before popping
  assign pop        = valid && (!is_mem || data_done);
  assign data_req   = valid && is_mem;
  assign data_write = data_req && (op == OP_STR);
  assign data_addr  = addr_t'(rs_data) + addr_t'(head[5:0]);
  assign data_wdata = rd_data;

  assign wr_en   = pop && writes_reg;
  assign wr_data = (op == OP_LDR) ? rdata : alu_result;

  // Flags held as N Z C V, bit 1 feeds ADC
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      flags_q  <= '0;
      halted_q <= 1'b0;
    end else if (pop) begin
      if (sets_nz) begin
        flags_q[3:2] <= {alu_n, alu_z};
      end
      if (sets_cv) begin
        flags_q[1:0] <= {alu_c, alu_v};
      end
      if (op == OP_HALT) begin
        halted_q <= 1'b1;
      end
    end
  end

  assign halted = halted_q;

  register_file u_regs (
    .clock   (clock),
    .arst_n  (arst_n),
    .rs_sel  (rs_idx),
    .rt_sel  (rt_idx),
    .rd_sel  (rd_idx),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_sel  (rd_idx),
    .wr_data (wr_data)
  );

  alu u_alu (
    .op       (alu_op),
    .a        (rs_data),
    .b        (alu_b),
    .carry_in (flags_q[1]),
    .result   (alu_result),
    .n        (alu_n),
    .z        (alu_z),
    .c        (alu_c),
    .v        (alu_v)
  );

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`default_nettype none

`include "cpu_defines.svh"

module fetch_unit (
  input  wire                 clock,
  input  wire                 arst_n,
  input  wire                 full,
  input  wire                 fetch_done,
  input  wire cpu_pkg::word_t rdata,
  output logic                fetch_req,
  output cpu_pkg::addr_t      fetch_addr,
  output logic                push,
  output cpu_pkg::word_t      push_data
);

  import cpu_pkg::*;

  addr_t pc_q;
  logic  req_q;

  // ********************
  // Request
  // ********************

  // A new fetch starts only with room in the queue.
  // Once issued it is held until its done pulse
  assign fetch_req  = req_q | ~full;
  assign fetch_addr = pc_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      req_q <= 1'b0;
    end else if (fetch_done) begin
      req_q <= 1'b0;
    end else if (fetch_req) begin
      req_q <= 1'b1;
    end
  end

  // ********************
  // PC and queue fill
  // ********************

  // Wraps at the top of the address space
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= addr_t'(`CPU_RESET_PC);
    end else if (fetch_done) begin
      pc_q <= pc_q + 1'b1;
    end
  end

  // Read data goes straight into the queue
  assign push      = fetch_done;
  assign push_data = rdata;

endmodule

`default_nettype wire

// File: design/instr_queue.sv
`default_nettype none

`include "cpu_defines.svh"

module instr_queue #(
  // Power of two, two or more
  parameter int DEPTH = `CPU_QUEUE_DEPTH
) (
  input  wire                 clock,
  input  wire                 arst_n,
  input  wire                 push,
  input  wire cpu_pkg::word_t push_data,
  input  wire                 pop,
  output cpu_pkg::word_t      head,
  output logic                empty,
  output logic                full
);

  import cpu_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Pointers wrap on their own width
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data;
    end
  end

  assign head  = mem[rd_ptr_q];
  assign empty = (count_q == '0);
  assign full  = (count_q == CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
  input  wire                 clock,
  input  wire                 arst_n,
  input  wire                 fetch_req,
  input  wire cpu_pkg::addr_t fetch_addr,
  input  wire                 data_req,
  input  wire                 data_write,
  input  wire cpu_pkg::addr_t data_addr,
  input  wire cpu_pkg::word_t data_wdata,
  output logic                fetch_done,
  output logic                data_done,
  output cpu_pkg::word_t      rdata,
  output logic                psel,
  output logic                penable,
  output logic                pwrite,
  output cpu_pkg::addr_t      paddr,
  output cpu_pkg::word_t      pwdata,
  input  wire cpu_pkg::word_t prdata,
  input  wire                 pready
);

  import cpu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e state_q;
  logic   owner_data_q;
  logic   write_q;
  addr_t  addr_q;
  word_t  wdata_q;
  logic   xfer_done;

  // ********************
  // Grant and sequencing
  // ********************

  // Data channel wins a tie
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q      <= ST_IDLE;
      owner_data_q <= 1'b0;
      write_q      <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (data_req || fetch_req) begin
            state_q      <= ST_SETUP;
            owner_data_q <= data_req;
            write_q      <= data_req && data_write;
          end
        end
        ST_SETUP: state_q <= ST_ACCESS;
        ST_ACCESS: begin
          if (pready) begin
            state_q <= ST_IDLE;
            write_q <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Captured at grant, stable through the transfer
  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE) begin
      addr_q  <= data_req ? data_addr : fetch_addr;
      wdata_q <= data_wdata;
    end
  end

  // ********************
  // APB drive
  // ********************

  assign psel    = (state_q != ST_IDLE);
  assign penable = (state_q == ST_ACCESS);
  assign pwrite  = write_q;
  assign paddr   = addr_q;
  assign pwdata  = wdata_q;

  assign xfer_done  = penable && pready;
  assign fetch_done = xfer_done && !owner_data_q;
  assign data_done  = xfer_done && owner_data_q;
  assign rdata      = prdata;

endmodule

`default_nettype wire

// File: design/register_file.sv
`default_nettype none

`include "cpu_defines.svh"

module register_file (
  input  wire                      clock,
  input  wire                      arst_n,
  input  wire cpu_pkg::reg_idx_t   rs_sel,
  input  wire cpu_pkg::reg_idx_t   rt_sel,
  input  wire cpu_pkg::reg_idx_t   rd_sel,
  output cpu_pkg::word_t           rs_data,
  output cpu_pkg::word_t           rt_data,
  output cpu_pkg::word_t           rd_data,
  input  wire                      wr_en,
  input  wire cpu_pkg::reg_idx_t   wr_sel,
  input  wire cpu_pkg::word_t      wr_data
);

  import cpu_pkg::*;

  word_t regs [`CPU_REG_COUNT];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_sel] <= wr_data;
    end
  end

  // Combinational reads, rd port supplies store data
  assign rs_data = regs[rs_sel];
  assign rt_data = regs[rt_sel];
  assign rd_data = regs[rd_sel];

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
+incdir+bench
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/execute_unit.sv
design/instr_queue.sv
design/fetch_unit.sv
design/mem_arbiter.sv
design/cpu_top.sv
bench/cpu_tb.sv
